//--- lvt_dual_core.f
verilog/lvt_pkg.sv
verilog/regfile_bank.sv
verilog/regfile_lvt.sv
verilog/issue_stage.sv
verilog/exec_stage.sv
verilog/lvt_dual_core.sv
verif/tb_lvt_dual_core.sv

//--- verif/tb_lvt_dual_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lvt_dual_core;

	// One expected retire for every accepted lane that is not empty
	typedef struct packed {
		logic [31:0] due;
		logic lane;
		lvt_pkg::regno_t dst;
		lvt_pkg::value_t value;
		lvt_pkg::flags_t flags;
	} exp_t;

	// All tests together take well under a thousand cycles
	localparam int CYCLE_LIMIT = 2000;
	// Signed 32-bit range for the overflow rule
	localparam longint MAX_S = 64'sh0000_0000_7fff_ffff;
	localparam longint MIN_S = -64'sh0000_0000_8000_0000;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	lvt_pkg::insn_t in_insn0;
	lvt_pkg::insn_t in_insn1;
	logic ret_valid0;
	logic ret_valid1;
	lvt_pkg::regno_t ret_dst0;
	lvt_pkg::regno_t ret_dst1;
	lvt_pkg::value_t ret_value0;
	lvt_pkg::value_t ret_value1;
	lvt_pkg::flags_t ret_flags0;
	lvt_pkg::flags_t ret_flags1;

	// Architectural register model updated in program order
	lvt_pkg::value_t model_val [lvt_pkg::PREGS];
	exp_t exp_q [$];
	int cycle;
	int seed;
	int pushed;
	int retired;
	int err_value;
	int err_flags;
	int err_dst;
	int err_other;

	lvt_dual_core DUT (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_insn0   (in_insn0),
		.in_insn1   (in_insn1),
		.ret_valid0 (ret_valid0),
		.ret_valid1 (ret_valid1),
		.ret_dst0   (ret_dst0),
		.ret_dst1   (ret_dst1),
		.ret_value0 (ret_value0),
		.ret_value1 (ret_value1),
		.ret_flags0 (ret_flags0),
		.ret_flags1 (ret_flags1)
	);

	// 40 ns clock where cycle counts rising edges
	initial begin
		clk = 1'b0;
		cycle = 0;
		forever begin
			#20 clk = ~clk;
			if (clk) begin
				cycle++;
			end
		end
	end

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_value(input string name, input lvt_pkg::value_t got,
		input lvt_pkg::value_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			err_value++;
		end
	endtask

	task automatic check_flags(input string name, input lvt_pkg::flags_t got,
		input lvt_pkg::flags_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			err_flags++;
		end
	endtask

	task automatic check_dst(input string name, input lvt_pkg::regno_t got,
		input lvt_pkg::regno_t exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			err_dst++;
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d value, %0d flags, %0d dst, %0d other",
			err_value, err_flags, err_dst, err_other);
	endtask

	// ========================================
	// Instruction words and reference model
	// ========================================

	function automatic lvt_pkg::insn_t reg_insn(input lvt_pkg::opcode_t op,
		input lvt_pkg::regno_t dst, input lvt_pkg::regno_t s1, input lvt_pkg::regno_t s2);
		lvt_pkg::insn_t w;
		w.r.opcode = op;
		w.r.dst = dst;
		w.r.src1 = s1;
		w.r.src2 = s2;
		w.r.unused = '0;
		return w;
	endfunction

	function automatic lvt_pkg::insn_t imm_insn(input lvt_pkg::opcode_t op,
		input lvt_pkg::regno_t dst, input lvt_pkg::regno_t s1, input logic [17:0] imm);
		lvt_pkg::insn_t w;
		w.i.opcode = op;
		w.i.dst = dst;
		w.i.src1 = s1;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic lvt_pkg::insn_t nop_insn();
		return reg_insn(lvt_pkg::OP_NOP, 5'd0, 5'd0, 5'd0);
	endfunction

	// Results worked out in 64-bit arithmetic from the flag rules
	task automatic model_alu(input lvt_pkg::opcode_t op, input lvt_pkg::value_t a,
		input lvt_pkg::value_t b, output lvt_pkg::value_t r, output lvt_pkg::flags_t f);
		longint wide;
		longint sa;
		longint sb;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		f = '0;
		case (op)
			lvt_pkg::OP_ADD, lvt_pkg::OP_ADDI: begin
				wide = longint'(a) + longint'(b);
				r = wide[31:0];
				f.c = wide > 64'sh0000_0000_ffff_ffff;
				f.v = (sa + sb) > MAX_S || (sa + sb) < MIN_S;
			end
			lvt_pkg::OP_SUB: begin
				r = a - b;
				// Borrow whenever b is the larger unsigned number
				f.c = a < b;
				f.v = (sa - sb) > MAX_S || (sa - sb) < MIN_S;
			end
			lvt_pkg::OP_AND: r = a & b;
			lvt_pkg::OP_OR:  r = a | b;
			lvt_pkg::OP_XOR: r = a ^ b;
			lvt_pkg::OP_SHL: r = a << b[4:0];
			lvt_pkg::OP_LDI: r = b;
			default: r = '0;
		endcase
		f.z = (r == 32'd0);
		f.n = r[31];
	endtask

	// Runs one lane through the model and queues its retire
	task automatic apply_lane(input lvt_pkg::insn_t w, input logic lane, input int due);
		lvt_pkg::value_t a;
		lvt_pkg::value_t b;
		lvt_pkg::value_t r;
		lvt_pkg::flags_t f;
		exp_t e;
		if (w.r.opcode != lvt_pkg::OP_NOP) begin
			a = model_val[w.r.src1];
			if (w.r.opcode == lvt_pkg::OP_ADDI || w.r.opcode == lvt_pkg::OP_LDI) begin
				b = {{14{w.i.imm[17]}}, w.i.imm};
			end else begin
				b = model_val[w.r.src2];
			end
			model_alu(w.r.opcode, a, b, r, f);
			model_val[w.r.dst] = r;
			e.due = due;
			e.lane = lane;
			e.dst = w.r.dst;
			e.value = r;
			e.flags = f;
			exp_q.push_back(e);
			pushed++;
		end
	endtask

	// ========================================
	// Driving and retire monitor
	// ========================================

	// Holds the pair until in_ready and returns the cycles spent waiting
	task automatic send_pair(input lvt_pkg::insn_t w0, input lvt_pkg::insn_t w1,
		output int stalls);
		logic accepted;
		stalls = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_insn0 = w0;
			in_insn1 = w1;
			#1;
			if (in_ready) begin
				accepted = 1'b1;
				// The next edge accepts and the result shows after the edge after it
				apply_lane(w0, 1'b0, cycle + 2);
				apply_lane(w1, 1'b1, cycle + 2);
			end else begin
				stalls++;
			end
			@(posedge clk);
		end
	endtask

	task automatic go_idle();
		@(negedge clk);
		in_valid = 1'b0;
		in_insn0 = nop_insn();
		in_insn1 = nop_insn();
	endtask

	function automatic int first_of_lane(input logic lane);
		int idx;
		idx = -1;
		for (int i = exp_q.size() - 1; i >= 0; i--) begin
			if (exp_q[i].lane == lane) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic watch_lane(input logic lane, input logic v, input lvt_pkg::regno_t d,
		input lvt_pkg::value_t val, input lvt_pkg::flags_t f);
		int idx;
		idx = first_of_lane(lane);
		// Entries whose cycle has passed without a retire are lost
		while (idx >= 0 && exp_q[idx].due < cycle) begin
			$display("missing retire on lane %0d for r%0d, due in cycle %0d",
				lane, exp_q[idx].dst, exp_q[idx].due);
			err_other++;
			exp_q.delete(idx);
			idx = first_of_lane(lane);
		end
		if (v) begin
			retired++;
			if (idx < 0 || exp_q[idx].due != cycle) begin
				$display("unexpected retire on lane %0d in cycle %0d", lane, cycle);
				err_other++;
			end else begin
				check_dst(lane ? "ret_dst1" : "ret_dst0", d, exp_q[idx].dst);
				check_value(lane ? "ret_value1" : "ret_value0", val, exp_q[idx].value);
				check_flags(lane ? "ret_flags1" : "ret_flags0", f, exp_q[idx].flags);
				exp_q.delete(idx);
			end
		end
	endtask

	// Retire outputs change on the rising edge and are read on the falling one
	always @(negedge clk) begin
		if (!rst) begin
			watch_lane(1'b0, ret_valid0, ret_dst0, ret_value0, ret_flags0);
			watch_lane(1'b1, ret_valid1, ret_dst1, ret_value1, ret_flags1);
		end
	end

	task automatic wait_drain();
		go_idle();
		while (exp_q.size() != 0) begin
			@(negedge clk);
			#1;
		end
		// Quiet cycles so that any extra retire is caught too
		repeat (3) @(negedge clk);
		#1;
		if (retired != pushed) begin
			$display("retire count %0d does not match %0d accepted lanes", retired, pushed);
			err_other++;
		end
	endtask

	// Loads a full word in three pairs while r31 holds the shift and then the low half
	task automatic load_value(input lvt_pkg::regno_t r, input lvt_pkg::value_t v);
		int stalls;
		send_pair(imm_insn(lvt_pkg::OP_LDI, r, 5'd0, {2'b00, v[31:16]}),
			imm_insn(lvt_pkg::OP_LDI, 5'd31, 5'd0, 18'd16), stalls);
		send_pair(reg_insn(lvt_pkg::OP_SHL, r, r, 5'd31),
			imm_insn(lvt_pkg::OP_LDI, 5'd31, 5'd0, {2'b00, v[15:0]}), stalls);
		send_pair(reg_insn(lvt_pkg::OP_OR, r, r, 5'd31), nop_insn(), stalls);
	endtask

	function automatic lvt_pkg::regno_t pick_reg(input lvt_pkg::regno_t avoid);
		lvt_pkg::regno_t r;
		r = avoid;
		// Twelve registers keep dependencies and lane switches frequent
		while (r == avoid) begin
			r = lvt_pkg::regno_t'($unsigned($random(seed)) % 12);
		end
		return r;
	endfunction

	// Random word whose sources never equal the register in avoid
	function automatic lvt_pkg::insn_t random_insn(input lvt_pkg::regno_t avoid);
		int pick;
		lvt_pkg::regno_t d;
		lvt_pkg::regno_t s1;
		lvt_pkg::regno_t s2;
		lvt_pkg::insn_t w;
		pick = int'($unsigned($random(seed)) % 10);
		d = pick_reg(5'd31);
		s1 = pick_reg(avoid);
		s2 = pick_reg(avoid);
		if (pick == 0) begin
			w = nop_insn();
		end else if (pick <= 6) begin
			w = reg_insn(lvt_pkg::opcode_t'(pick), d, s1, s2);
		end else if (pick == 7) begin
			w = imm_insn(lvt_pkg::OP_ADDI, d, s1, 18'($random(seed)));
		end else begin
			w = imm_insn(lvt_pkg::OP_LDI, d, 5'd0, 18'($random(seed)));
		end
		return w;
	endfunction

	// ========================================
	// Tests
	// ========================================

	task automatic immediates_after_reset();
		logic [17:0] imms [8];
		int stalls;
		imms = '{18'h00005, 18'h3ffff, 18'h1ffff, 18'h20000,
			18'h00000, 18'h2abcd, 18'h12345, 18'h3ff00};
		#1;
		if (in_ready !== 1'b1 || ret_valid0 !== 1'b0 || ret_valid1 !== 1'b0) begin
			$display("after reset in_ready is not high or a retire is already showing");
			err_other++;
		end
		// r0 still reads zero, so each result is its own immediate
		for (int i = 0; i < 4; i++) begin
			send_pair(imm_insn(lvt_pkg::OP_ADDI, 5'(2*i+1), 5'd0, imms[2*i]),
				imm_insn(lvt_pkg::OP_ADDI, 5'(2*i+2), 5'd0, imms[2*i+1]), stalls);
		end
		wait_drain();
	endtask

	task automatic alu_ops_and_flags();
		lvt_pkg::opcode_t ops [6];
		int stalls;
		ops = '{lvt_pkg::OP_ADD, lvt_pkg::OP_SUB, lvt_pkg::OP_AND,
			lvt_pkg::OP_OR, lvt_pkg::OP_XOR, lvt_pkg::OP_SHL};
		load_value(5'd1, 32'h7fff_ffff);
		load_value(5'd2, 32'h0000_0001);
		load_value(5'd3, 32'hffff_ffff);
		load_value(5'd4, 32'h8000_0000);
		load_value(5'd5, 32'h0000_0000);
		// Signed overflow, then carry out with a zero result
		send_pair(reg_insn(lvt_pkg::OP_ADD, 5'd10, 5'd1, 5'd2),
			reg_insn(lvt_pkg::OP_ADD, 5'd11, 5'd3, 5'd2), stalls);
		// Borrow from zero, then overflow past the most negative value
		send_pair(reg_insn(lvt_pkg::OP_SUB, 5'd12, 5'd5, 5'd2),
			reg_insn(lvt_pkg::OP_SUB, 5'd13, 5'd4, 5'd2), stalls);
		send_pair(reg_insn(lvt_pkg::OP_SUB, 5'd14, 5'd1, 5'd1),
			reg_insn(lvt_pkg::OP_ADD, 5'd15, 5'd4, 5'd4), stalls);
		for (int k = 0; k < 6; k++) begin
			for (int n = 0; n < 2; n++) begin
				load_value(5'd6, $random(seed));
				load_value(5'd7, $random(seed));
				send_pair(reg_insn(ops[k], 5'd16, 5'd6, 5'd7),
					reg_insn(ops[k], 5'd17, 5'd7, 5'd6), stalls);
			end
		end
		wait_drain();
	endtask

	task automatic same_dst_both_lanes();
		int stalls;
		send_pair(imm_insn(lvt_pkg::OP_LDI, 5'd5, 5'd0, 18'd111),
			imm_insn(lvt_pkg::OP_LDI, 5'd5, 5'd0, 18'd222), stalls);
		// Read through the bypass in the retire cycle
		send_pair(reg_insn(lvt_pkg::OP_ADD, 5'd6, 5'd5, 5'd0), nop_insn(), stalls);
		wait_drain();
		// And from the bank that the table now names for r5
		send_pair(reg_insn(lvt_pkg::OP_ADD, 5'd7, 5'd5, 5'd0),
			reg_insn(lvt_pkg::OP_ADD, 5'd8, 5'd0, 5'd5), stalls);
		send_pair(imm_insn(lvt_pkg::OP_LDI, 5'd5, 5'd0, 18'd333), nop_insn(), stalls);
		wait_drain();
		send_pair(nop_insn(), reg_insn(lvt_pkg::OP_ADD, 5'd9, 5'd5, 5'd0), stalls);
		wait_drain();
	endtask

	task automatic back_to_back_dependency();
		int stalls;
		int total;
		total = 0;
		send_pair(imm_insn(lvt_pkg::OP_ADDI, 5'd1, 5'd0, 18'd5),
			imm_insn(lvt_pkg::OP_ADDI, 5'd2, 5'd0, 18'd7), stalls);
		send_pair(reg_insn(lvt_pkg::OP_ADD, 5'd3, 5'd1, 5'd2), nop_insn(), stalls);
		if (stalls == 0) begin
			$display("in_ready stayed high while r1 and r2 were still pending");
			err_other++;
		end
		send_pair(reg_insn(lvt_pkg::OP_SUB, 5'd4, 5'd3, 5'd1),
			imm_insn(lvt_pkg::OP_ADDI, 5'd5, 5'd2, 18'd1), stalls);
		total += stalls;
		send_pair(reg_insn(lvt_pkg::OP_XOR, 5'd6, 5'd4, 5'd5),
			reg_insn(lvt_pkg::OP_SHL, 5'd7, 5'd3, 5'd2), stalls);
		total += stalls;
		if (total == 0) begin
			$display("in_ready never dropped along the dependency chain");
			err_other++;
		end
		wait_drain();
	endtask

	task automatic random_pair_stream();
		lvt_pkg::insn_t w [2];
		int last_lane [lvt_pkg::PREGS];
		int switches;
		int stalls;
		switches = 0;
		for (int i = 0; i < lvt_pkg::PREGS; i++) begin
			last_lane[i] = -1;
		end
		for (int n = 0; n < 120; n++) begin
			w[0] = random_insn(5'd31);
			w[1] = random_insn(w[0].r.dst);
			send_pair(w[0], w[1], stalls);
			// Track how often the last writer of a register moves between lanes
			for (int l = 0; l < 2; l++) begin
				if (w[l].r.opcode != lvt_pkg::OP_NOP) begin
					if (last_lane[w[l].r.dst] >= 0 && last_lane[w[l].r.dst] != l) begin
						switches++;
					end
					last_lane[w[l].r.dst] = l;
				end
			end
		end
		wait_drain();
		if (switches == 0) begin
			$display("the random stream never moved a register between lanes");
			err_other++;
		end
	endtask

	// ========================================
	// Main sequence and timeout
	// ========================================

	initial begin
		seed = 32'h1747;
		pushed = 0;
		retired = 0;
		err_value = 0;
		err_flags = 0;
		err_dst = 0;
		err_other = 0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_insn0 = '0;
		in_insn1 = '0;
		for (int i = 0; i < lvt_pkg::PREGS; i++) begin
			model_val[i] = '0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		immediates_after_reset();
		alu_ops_and_flags();
		same_dst_both_lanes();
		back_to_back_dependency();
		random_pair_stream();
		print_counts();
		if (err_value + err_flags + err_dst + err_other == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		wait (cycle >= CYCLE_LIMIT);
		$display("timeout after %0d cycles with %0d retires still expected",
			cycle, exp_q.size());
		print_counts();
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
	input wire clk,
	input wire rst,
	input wire iss_valid [lvt_pkg::WPORTS],
	input wire lvt_pkg::opcode_t iss_op [lvt_pkg::WPORTS],
	input wire lvt_pkg::regno_t iss_dst [lvt_pkg::WPORTS],
	input wire lvt_pkg::value_t iss_a [lvt_pkg::WPORTS],
	input wire lvt_pkg::value_t iss_b [lvt_pkg::WPORTS],
	output logic wb_valid [lvt_pkg::WPORTS],
	output lvt_pkg::regno_t wb_dst [lvt_pkg::WPORTS],
	output lvt_pkg::value_t wb_value [lvt_pkg::WPORTS],
	output lvt_pkg::flags_t wb_flags [lvt_pkg::WPORTS]
);

	// Operand registers are loaded on the edge that accepts the pair
	logic op_valid [lvt_pkg::WPORTS];
	lvt_pkg::opcode_t op_op [lvt_pkg::WPORTS];
	lvt_pkg::regno_t op_dst [lvt_pkg::WPORTS];
	lvt_pkg::value_t op_a [lvt_pkg::WPORTS];
	lvt_pkg::value_t op_b [lvt_pkg::WPORTS];
	// ALU outputs
	lvt_pkg::value_t res [lvt_pkg::WPORTS];
	lvt_pkg::flags_t flg [lvt_pkg::WPORTS];

	// ========================================
	// Pipeline registers
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
				op_valid[l] <= 1'b0;
				wb_valid[l] <= 1'b0;
			end
		end else begin
			for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
				op_valid[l] <= iss_valid[l];
				wb_valid[l] <= op_valid[l];
			end
		end
	end

	// Payload follows the valid bits one stage at a time
	always_ff @(posedge clk) begin
		for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
			op_op[l] <= iss_op[l];
			op_dst[l] <= iss_dst[l];
			op_a[l] <= iss_a[l];
			op_b[l] <= iss_b[l];
			wb_dst[l] <= op_dst[l];
			wb_value[l] <= res[l];
			wb_flags[l] <= flg[l];
		end
	end

	// ========================================
	// ALUs
	// ========================================

	always_comb begin
		logic [lvt_pkg::XLEN:0] sum;
		logic [lvt_pkg::XLEN:0] diff;
		for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
			// Both use one extra bit so carry and borrow fall out of the top
			sum = {1'b0, op_a[l]} + {1'b0, op_b[l]};
			diff = {1'b0, op_a[l]} - {1'b0, op_b[l]};
			flg[l].c = 1'b0;
			flg[l].v = 1'b0;
			case (op_op[l])
				lvt_pkg::OP_ADD, lvt_pkg::OP_ADDI: begin
					res[l] = sum[lvt_pkg::XLEN-1:0];
					flg[l].c = sum[lvt_pkg::XLEN];
					// Same-sign inputs with a differently signed result
					flg[l].v = (op_a[l][lvt_pkg::XLEN-1] == op_b[l][lvt_pkg::XLEN-1])
						&& (res[l][lvt_pkg::XLEN-1] != op_a[l][lvt_pkg::XLEN-1]);
				end
				lvt_pkg::OP_SUB: begin
					res[l] = diff[lvt_pkg::XLEN-1:0];
					// Top bit is set when b is the larger unsigned number
					flg[l].c = diff[lvt_pkg::XLEN];
					flg[l].v = (op_a[l][lvt_pkg::XLEN-1] != op_b[l][lvt_pkg::XLEN-1])
						&& (res[l][lvt_pkg::XLEN-1] != op_a[l][lvt_pkg::XLEN-1]);
				end
				lvt_pkg::OP_AND: res[l] = op_a[l] & op_b[l];
				lvt_pkg::OP_OR:  res[l] = op_a[l] | op_b[l];
				lvt_pkg::OP_XOR: res[l] = op_a[l] ^ op_b[l];
				// Only the low five bits of b count as the shift amount
				lvt_pkg::OP_SHL: res[l] = op_a[l] << op_b[l][lvt_pkg::RBITS-1:0];
				lvt_pkg::OP_LDI: res[l] = op_b[l];
				default: res[l] = '0;
			endcase
			flg[l].z = (res[l] == '0);
			flg[l].n = res[l][lvt_pkg::XLEN-1];
		end
	end

endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
	input wire clk,
	input wire rst,
	input wire in_valid,
	output logic in_ready,
	input wire lvt_pkg::insn_t in_insn0,
	input wire lvt_pkg::insn_t in_insn1,
	output lvt_pkg::regno_t rd_addr [lvt_pkg::RPORTS],
	input wire lvt_pkg::value_t rd_value [lvt_pkg::RPORTS],
	input wire wb_valid [lvt_pkg::WPORTS],
	input wire lvt_pkg::regno_t wb_dst [lvt_pkg::WPORTS],
	output logic iss_valid [lvt_pkg::WPORTS],
	output lvt_pkg::opcode_t iss_op [lvt_pkg::WPORTS],
	output lvt_pkg::regno_t iss_dst [lvt_pkg::WPORTS],
	output lvt_pkg::value_t iss_a [lvt_pkg::WPORTS],
	output lvt_pkg::value_t iss_b [lvt_pkg::WPORTS]
);

	// Per-lane decode results
	lvt_pkg::insn_t insn [lvt_pkg::WPORTS];
	lvt_pkg::opcode_t op [lvt_pkg::WPORTS];
	logic known [lvt_pkg::WPORTS];
	logic uses_a [lvt_pkg::WPORTS];
	logic uses_b [lvt_pkg::WPORTS];
	logic imm_form [lvt_pkg::WPORTS];
	logic writes [lvt_pkg::WPORTS];
	logic hazard [lvt_pkg::WPORTS];
	lvt_pkg::value_t imm_ext [lvt_pkg::WPORTS];
	// Scoreboard, one bit per register with a write in flight
	logic [lvt_pkg::PREGS-1:0] pending;
	// Registers being written back in this cycle
	logic [lvt_pkg::PREGS-1:0] wb_hit;
	logic [lvt_pkg::PREGS-1:0] busy;

	// ========================================
	// Decode
	// ========================================

	always_comb begin
		insn[0] = in_insn0;
		insn[1] = in_insn1;
		for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
			op[l] = insn[l].r.opcode;
			known[l] = 1'b1;
			uses_a[l] = 1'b0;
			uses_b[l] = 1'b0;
			imm_form[l] = 1'b0;
			case (op[l])
				lvt_pkg::OP_NOP: ;
				lvt_pkg::OP_ADD, lvt_pkg::OP_SUB, lvt_pkg::OP_AND,
				lvt_pkg::OP_OR, lvt_pkg::OP_XOR, lvt_pkg::OP_SHL: begin
					uses_a[l] = 1'b1;
					uses_b[l] = 1'b1;
				end
				lvt_pkg::OP_ADDI: begin
					uses_a[l] = 1'b1;
					imm_form[l] = 1'b1;
				end
				lvt_pkg::OP_LDI: imm_form[l] = 1'b1;
				default: known[l] = 1'b0;
			endcase
			// An empty or undefined lane produces no retire
			writes[l] = known[l] && op[l] != lvt_pkg::OP_NOP;
			imm_ext[l] = {{(lvt_pkg::XLEN - lvt_pkg::IMM_BITS){insn[l].i.imm[lvt_pkg::IMM_BITS-1]}},
				insn[l].i.imm};
			// Lane 0 reads through ports 0 and 1, lane 1 through 2 and 3
			rd_addr[2*l] = insn[l].r.src1;
			rd_addr[2*l+1] = insn[l].r.src2;
		end
	end

	// ========================================
	// Hazards
	// ========================================

	// A register retiring this cycle is bypassed by the register file,
	// so only writes still in the operand stage count as busy.
	// A lane whose destination is busy also waits; this keeps at most one
	// write per register in flight so the bypass always holds the newest value
	always_comb begin
		wb_hit = '0;
		for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
			if (wb_valid[l]) begin
				wb_hit[wb_dst[l]] = 1'b1;
			end
		end
		busy = pending & ~wb_hit;
		in_ready = 1'b1;
		for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
			hazard[l] = (uses_a[l] && busy[insn[l].r.src1])
				|| (uses_b[l] && busy[insn[l].r.src2])
				|| (writes[l] && busy[insn[l].r.dst]);
			if (hazard[l]) begin
				in_ready = 1'b0;
			end
		end
	end

	// ========================================
	// Issue
	// ========================================

	always_comb begin
		for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
			iss_valid[l] = in_valid && in_ready && writes[l];
			iss_op[l] = op[l];
			iss_dst[l] = insn[l].r.dst;
			iss_a[l] = rd_value[2*l];
			iss_b[l] = imm_form[l] ? imm_ext[l] : rd_value[2*l+1];
		end
	end

	// Set on acceptance and cleared on writeback; a set on the same edge wins
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
				if (wb_valid[l]) begin
					pending[wb_dst[l]] <= 1'b0;
				end
			end
			for (int l = 0; l < lvt_pkg::WPORTS; l++) begin
				if (iss_valid[l]) begin
					pending[iss_dst[l]] <= 1'b1;
				end
			end
		end
	end

	// Lane 1 must not read the register that lane 0 of the same pair writes
	a_pair_indep: assert property (@(posedge clk) disable iff (rst)
		in_valid && writes[0] |->
			!(uses_a[1] && insn[1].r.src1 == insn[0].r.dst)
			&& !(uses_b[1] && insn[1].r.src2 == insn[0].r.dst));

	// The source never hands over an undefined opcode
	a_known_op: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready |-> known[0] && known[1]);

endmodule

`default_nettype wire

//--- verilog/lvt_dual_core.sv
`timescale 1ns/1ns
`default_nettype none

module lvt_dual_core (
	input wire clk,
	input wire rst,
	input wire in_valid,
	output logic in_ready,
	input wire lvt_pkg::insn_t in_insn0,
	input wire lvt_pkg::insn_t in_insn1,
	output logic ret_valid0,
	output logic ret_valid1,
	output lvt_pkg::regno_t ret_dst0,
	output lvt_pkg::regno_t ret_dst1,
	output lvt_pkg::value_t ret_value0,
	output lvt_pkg::value_t ret_value1,
	output lvt_pkg::flags_t ret_flags0,
	output lvt_pkg::flags_t ret_flags1
);

	// Read path between issue and the register file
	lvt_pkg::regno_t rd_addr [lvt_pkg::RPORTS];
	lvt_pkg::value_t rd_value [lvt_pkg::RPORTS];
	// Issue to execute
	logic iss_valid [lvt_pkg::WPORTS];
	lvt_pkg::opcode_t iss_op [lvt_pkg::WPORTS];
	lvt_pkg::regno_t iss_dst [lvt_pkg::WPORTS];
	lvt_pkg::value_t iss_a [lvt_pkg::WPORTS];
	lvt_pkg::value_t iss_b [lvt_pkg::WPORTS];
	// Writeback, shared by the register file, the scoreboard and retire
	logic wb_valid [lvt_pkg::WPORTS];
	lvt_pkg::regno_t wb_dst [lvt_pkg::WPORTS];
	lvt_pkg::value_t wb_value [lvt_pkg::WPORTS];
	lvt_pkg::flags_t wb_flags [lvt_pkg::WPORTS];

	issue_stage u_issue (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_insn0  (in_insn0),
		.in_insn1  (in_insn1),
		.rd_addr   (rd_addr),
		.rd_value  (rd_value),
		.wb_valid  (wb_valid),
		.wb_dst    (wb_dst),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_dst   (iss_dst),
		.iss_a     (iss_a),
		.iss_b     (iss_b)
	);

	exec_stage u_exec (
		.clk       (clk),
		.rst       (rst),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_dst   (iss_dst),
		.iss_a     (iss_a),
		.iss_b     (iss_b),
		.wb_valid  (wb_valid),
		.wb_dst    (wb_dst),
		.wb_value  (wb_value),
		.wb_flags  (wb_flags)
	);

	// Operand flags are not consumed by these ALUs
	regfile_lvt u_rf (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wb_valid),
		.wr_addr  (wb_dst),
		.wr_value (wb_value),
		.wr_flags (wb_flags),
		.rd_addr  (rd_addr),
		.rd_value (rd_value),
		.rd_flags ()
	);

	// Retire ports show the writeback registers directly
	assign ret_valid0 = wb_valid[0];
	assign ret_valid1 = wb_valid[1];
	assign ret_dst0 = wb_dst[0];
	assign ret_dst1 = wb_dst[1];
	assign ret_value0 = wb_value[0];
	assign ret_value1 = wb_value[1];
	assign ret_flags0 = wb_flags[0];
	assign ret_flags1 = wb_flags[1];

endmodule

`default_nettype wire

//--- verilog/lvt_pkg.sv
`default_nettype none

package lvt_pkg;

	// ========================================
	// Sizes
	// ========================================

	// Width of one register value
	localparam int XLEN = 32;
	// Number of architectural registers
	localparam int PREGS = 32;
	// Width of a register number
	localparam int RBITS = 5;
	// One write port per lane
	localparam int WPORTS = 2;
	// Two read ports per lane
	localparam int RPORTS = 4;
	// Immediate field of the immediate form
	localparam int IMM_BITS = 18;

	typedef logic [XLEN-1:0] value_t;
	typedef logic [RBITS-1:0] regno_t;

	// ========================================
	// Operations and flags
	// ========================================

	// Codes 9 to 15 are not defined and must never be accepted
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SHL  = 4'h6,
		OP_ADDI = 4'h7,
		OP_LDI  = 4'h8
	} opcode_t;

	// Zero, negative, carry (borrow for SUB) and signed overflow
	typedef struct packed {
		logic z;
		logic n;
		logic c;
		logic v;
	} flags_t;

	// Register form with three register numbers
	typedef struct packed {
		opcode_t     opcode;
		regno_t      dst;
		regno_t      src1;
		regno_t      src2;
		logic [12:0] unused;
	} insn_r_t;

	// Immediate form, the opcode sits in the same bits as above
	typedef struct packed {
		opcode_t                    opcode;
		regno_t                     dst;
		regno_t                     src1;
		logic signed [IMM_BITS-1:0] imm;
	} insn_i_t;

	// The issue stage picks the view from the opcode
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_t;

	// One bank entry keeps the flags next to the value
	typedef struct packed {
		flags_t flags;
		value_t value;
	} rf_word_t;

endpackage

`default_nettype wire

//--- verilog/regfile_bank.sv
`timescale 1ns/1ns
`default_nettype none

module regfile_bank (
	input wire clk,
	input wire we,
	input wire lvt_pkg::regno_t wa,
	input wire lvt_pkg::rf_word_t wd,
	input wire lvt_pkg::regno_t ra,
	output lvt_pkg::rf_word_t rd
);

	// One copy of the register file as seen by a single write port.
	// The parent keeps one bank for every pairing of a write port with a
	// read port, so every bank has exactly one writer and one reader
	lvt_pkg::rf_word_t mem [lvt_pkg::PREGS];

	// ========================================
	// Write side
	// ========================================

	// Whole entries only, value and flags together
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wa] <= wd;
		end
	end

	// ========================================
	// Read side
	// ========================================

	// Combinational read, so an operand is available in the issue cycle.
	// Entries never written since reset are masked off by the parent
	assign rd = mem[ra];

endmodule

`default_nettype wire

//--- verilog/regfile_lvt.sv
`timescale 1ns/1ns
`default_nettype none

module regfile_lvt (
	input wire clk,
	input wire rst,
	input wire wr_en [lvt_pkg::WPORTS],
	input wire lvt_pkg::regno_t wr_addr [lvt_pkg::WPORTS],
	input wire lvt_pkg::value_t wr_value [lvt_pkg::WPORTS],
	input wire lvt_pkg::flags_t wr_flags [lvt_pkg::WPORTS],
	input wire lvt_pkg::regno_t rd_addr [lvt_pkg::RPORTS],
	output lvt_pkg::value_t rd_value [lvt_pkg::RPORTS],
	output lvt_pkg::flags_t rd_flags [lvt_pkg::RPORTS]
);

	// Packed data word for each write port
	lvt_pkg::rf_word_t wr_word [lvt_pkg::WPORTS];
	// Bank outputs, first index is the write port, second the read port
	lvt_pkg::rf_word_t bank_rd [lvt_pkg::WPORTS][lvt_pkg::RPORTS];

	// Live value table.
	// lvt_port names the write port that last wrote each register
	logic [lvt_pkg::PREGS-1:0] lvt_port;
	// Set once a register has been written since reset, clear means zero
	logic [lvt_pkg::PREGS-1:0] lvt_live;

	always_comb begin
		for (int w = 0; w < lvt_pkg::WPORTS; w++) begin
			wr_word[w].flags = wr_flags[w];
			wr_word[w].value = wr_value[w];
		end
	end

	// ========================================
	// Banks
	// ========================================

	// Each write port feeds one bank per read port, eight banks in all
	for (genvar w = 0; w < lvt_pkg::WPORTS; w++) begin : g_wr
		for (genvar r = 0; r < lvt_pkg::RPORTS; r++) begin : g_rd
			regfile_bank u_bank (
				.clk (clk),
				.we  (wr_en[w]),
				.wa  (wr_addr[w]),
				.wd  (wr_word[w]),
				.ra  (rd_addr[r]),
				.rd  (bank_rd[w][r])
			);
		end
	end

	// ========================================
	// Live value table
	// ========================================

	// After reset every entry points to port 0 and reads as zero.
	// Ports are visited in order, so lane 1 wins a same-register write
	always_ff @(posedge clk) begin
		if (rst) begin
			lvt_port <= '0;
			lvt_live <= '0;
		end else begin
			for (int w = 0; w < lvt_pkg::WPORTS; w++) begin
				if (wr_en[w]) begin
					lvt_port[wr_addr[w]] <= 1'(w);
					lvt_live[wr_addr[w]] <= 1'b1;
				end
			end
		end
	end

	// ========================================
	// Read selection
	// ========================================

	always_comb begin
		lvt_pkg::rf_word_t sel;
		for (int r = 0; r < lvt_pkg::RPORTS; r++) begin
			// Stored copy from the bank that the table points at
			if (lvt_live[rd_addr[r]]) begin
				sel = bank_rd[lvt_port[rd_addr[r]]][r];
			end else begin
				sel = '0;
			end
			// A write in this same cycle overrides the stored copy.
			// Lane 1 is checked last so it takes priority over lane 0
			for (int w = 0; w < lvt_pkg::WPORTS; w++) begin
				if (wr_en[w] && wr_addr[w] == rd_addr[r]) begin
					sel = wr_word[w];
				end
			end
			rd_value[r] = sel.value;
			rd_flags[r] = sel.flags;
		end
	end

	// The retire path is held idle for as long as reset stays asserted
	a_no_wr_in_rst: assert property (@(posedge clk)
		rst ##1 rst |-> !wr_en[0] && !wr_en[1]);

endmodule

`default_nettype wire
